/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [31:0] imm_t;
    typedef logic [11:0] csr_idx_t;

    // major opcode, word bits 6..2
    typedef logic [4:0]  opc_t;

    localparam opc_t opc_load   = 5'b00000;
    localparam opc_t opc_op_imm = 5'b00100;
    localparam opc_t opc_auipc  = 5'b00101;
    localparam opc_t opc_store  = 5'b01000;
    localparam opc_t opc_op     = 5'b01100;
    localparam opc_t opc_lui    = 5'b01101;
    localparam opc_t opc_branch = 5'b11000;
    localparam opc_t opc_jalr   = 5'b11001;
    localparam opc_t opc_jal    = 5'b11011;
    localparam opc_t opc_system = 5'b11100;

    // low two bits of any 32-bit encoding
    localparam logic [1:0] opc_full = 2'b11;

    localparam funct3_t f3_zero = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    localparam logic [11:0] f12_ecall  = 12'h000;
    localparam logic [11:0] f12_ebreak = 12'h001;
    localparam logic [11:0] f12_mret   = 12'h302;

endpackage

`default_nettype wire

/* rv_ctrl_pkg.sv */
`default_nettype none

package rv_ctrl_pkg;

    // alu result select, at most one bit set
    typedef logic [3:0] alu_res_t;

    localparam int res_cmp   = 0;
    localparam int res_bits  = 1;
    localparam int res_shift = 2;
    localparam int res_arith = 3;

    // second alu operand: register, I/S/U immediate or J/B immediate
    typedef logic [2:0] op2_src_t;

    localparam int op2_r = 0;
    localparam int op2_i = 1;
    localparam int op2_j = 2;

    // register write-back source
    typedef logic [2:0] res_src_t;

    localparam int src_alu     = 0;
    localparam int src_pc_next = 1;
    localparam int src_mem     = 2;

endpackage

`default_nettype wire

/* rv_decode_reg.sv */
`default_nettype none

module rv_decode_reg
#(
    parameter int iaddr_bits = 32
)
(
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  wire                     i_stall,
    input  wire                     i_flush,
    input  wire                     i_ready,
    input  wire rv_isa_pkg::instr_t i_instruction,
    input  wire [iaddr_bits-1:1]    i_pc,
    output rv_isa_pkg::instr_t      o_instr,
    output logic                    o_valid,
    output logic [iaddr_bits-1:1]   o_pc,
    output logic [iaddr_bits-1:1]   o_pc_next
);

    rv_isa_pkg::instr_t instr_in;

    // empty slot enters as a zero word
    assign instr_in = i_ready ? i_instruction : '0;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_instr <= '0;
            o_valid <= 1'b0;
            o_pc    <= '0;
        end
        else if (i_flush)
        begin
            o_instr <= '0;
            o_valid <= 1'b0;
        end
        else if (!i_stall)
        begin
            o_instr <= instr_in;
            o_valid <= i_ready;
            o_pc    <= i_pc;
        end
    end

    // no compressed words, so always two halfwords ahead
    assign o_pc_next = o_pc + (iaddr_bits-1)'(2);

    // decoders rely on a zero word whenever the slot is empty
    empty_slot_zero: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        !o_valid |-> (o_instr == '0)
    ) else $error("empty slot holds a nonzero word");

endmodule

`default_nettype wire

/* rv_class_decode.sv */
`default_nettype none

module rv_class_decode
#(
    parameter bit ext_m     = 1'b1,
    parameter bit ext_zicsr = 1'b1
)
(
    input  wire rv_isa_pkg::instr_t  i_instr,
    input  wire                      i_valid,
    input  wire                      i_sys_legal,
    output rv_isa_pkg::reg_idx_t     o_rd,
    output rv_isa_pkg::reg_idx_t     o_rs1,
    output rv_isa_pkg::reg_idx_t     o_rs2,
    output rv_isa_pkg::funct3_t      o_funct3,
    output rv_ctrl_pkg::alu_res_t    o_alu_res,
    output rv_ctrl_pkg::op2_src_t    o_op2_src,
    output rv_ctrl_pkg::res_src_t    o_res_src,
    output logic                     o_op1_src,
    output logic                     o_alu_add_override,
    output logic                     o_alu_op1_inv,
    output logic                     o_alu_op2_inv,
    output logic                     o_alu_group_mux,
    output logic                     o_alu_div_mux,
    output logic                     o_reg_write,
    output logic                     o_supported,
    output logic                     o_inst_jal,
    output logic                     o_inst_jalr,
    output logic                     o_inst_branch,
    output logic                     o_inst_store,
    output logic                     o_is_system,
    output logic                     o_sel_u,
    output logic                     o_sel_s,
    output logic                     o_sel_j
);

    rv_isa_pkg::opc_t    opc;
    rv_isa_pkg::funct3_t f3;
    logic full;
    logic m_bit;
    logic alt_bit;
    logic grp_load, grp_ari, grp_store, grp_arr, grp_mul, grp_branch, grp_sys;
    logic auipc, lui, jal, jalr;
    logic slti, sltiu, xori, ori, andi, slli, srli, srai;
    logic add, sub, sll, slt, sltu, xor_r, srl, sra, or_r, and_r;

    assign opc     = i_instr[6:2];
    assign f3      = i_instr[14:12];
    assign full    = (i_instr[1:0] == rv_isa_pkg::opc_full);
    // funct7 bit 0 marks the M group, bit 5 sub/sra
    assign m_bit   = i_instr[25];
    assign alt_bit = i_instr[30];

    assign grp_load   = full & (opc == rv_isa_pkg::opc_load);
    assign grp_ari    = full & (opc == rv_isa_pkg::opc_op_imm);
    assign grp_store  = full & (opc == rv_isa_pkg::opc_store);
    assign grp_arr    = full & (opc == rv_isa_pkg::opc_op) & !m_bit;
    assign grp_mul    = full & (opc == rv_isa_pkg::opc_op) & m_bit & ext_m;
    assign grp_branch = full & (opc == rv_isa_pkg::opc_branch);
    assign grp_sys    = full & (opc == rv_isa_pkg::opc_system);
    assign auipc      = full & (opc == rv_isa_pkg::opc_auipc);
    assign lui        = full & (opc == rv_isa_pkg::opc_lui);
    assign jal        = full & (opc == rv_isa_pkg::opc_jal);
    assign jalr       = full & (opc == rv_isa_pkg::opc_jalr) & (f3 == rv_isa_pkg::f3_zero);

    assign slti  = grp_ari & (f3 == rv_isa_pkg::f3_slt);
    assign sltiu = grp_ari & (f3 == rv_isa_pkg::f3_sltu);
    assign xori  = grp_ari & (f3 == rv_isa_pkg::f3_xor);
    assign ori   = grp_ari & (f3 == rv_isa_pkg::f3_or);
    assign andi  = grp_ari & (f3 == rv_isa_pkg::f3_and);
    assign slli  = grp_ari & (f3 == rv_isa_pkg::f3_sll);
    assign srli  = grp_ari & (f3 == rv_isa_pkg::f3_sr) & !alt_bit;
    assign srai  = grp_ari & (f3 == rv_isa_pkg::f3_sr) & alt_bit;

    assign add   = grp_arr & (f3 == rv_isa_pkg::f3_zero) & !alt_bit;
    assign sub   = grp_arr & (f3 == rv_isa_pkg::f3_zero) & alt_bit;
    assign sll   = grp_arr & (f3 == rv_isa_pkg::f3_sll);
    assign slt   = grp_arr & (f3 == rv_isa_pkg::f3_slt);
    assign sltu  = grp_arr & (f3 == rv_isa_pkg::f3_sltu);
    assign xor_r = grp_arr & (f3 == rv_isa_pkg::f3_xor);
    assign srl   = grp_arr & (f3 == rv_isa_pkg::f3_sr) & !alt_bit;
    assign sra   = grp_arr & (f3 == rv_isa_pkg::f3_sr) & alt_bit;
    assign or_r  = grp_arr & (f3 == rv_isa_pkg::f3_or);
    assign and_r = grp_arr & (f3 == rv_isa_pkg::f3_and);

    assign o_rd     = i_instr[11:7];
    assign o_rs1    = lui ? '0 : i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_funct3 = f3;

    always_comb
    begin
        o_alu_res = '0;
        o_alu_res[rv_ctrl_pkg::res_cmp]   = |{grp_branch, slti, sltiu, slt, sltu};
        o_alu_res[rv_ctrl_pkg::res_bits]  = |{andi, and_r, ori, or_r, xori, xor_r};
        o_alu_res[rv_ctrl_pkg::res_shift] = |{slli, sll, srli, srl, srai, sra};
        o_alu_res[rv_ctrl_pkg::res_arith] = |{add, sub, grp_load, grp_store};

        o_op2_src = '0;
        o_op2_src[rv_ctrl_pkg::op2_j] = jal;
        o_op2_src[rv_ctrl_pkg::op2_i] = |{jalr, grp_load, grp_ari, lui, auipc, grp_store};
        o_op2_src[rv_ctrl_pkg::op2_r] =
            !(|{jal, jalr, grp_load, grp_ari, lui, auipc, grp_store});

        o_res_src = '0;
        o_res_src[rv_ctrl_pkg::src_mem]     = grp_load;
        o_res_src[rv_ctrl_pkg::src_pc_next] = jal | jalr;
        o_res_src[rv_ctrl_pkg::src_alu]     = !(grp_load | jal | jalr);
    end

    // compares subtract, so op2 is inverted for them
    always_comb
    begin
        if (grp_branch | slti | sltiu | slt | sltu | sra | srai)
            o_alu_op2_inv = 1'b1;
        else if (lui | auipc | jal | grp_load | grp_store | grp_ari)
            o_alu_op2_inv = 1'b0;
        else
            o_alu_op2_inv = alt_bit;
    end

    assign o_op1_src          = auipc | jal;
    assign o_alu_add_override = |{lui, auipc, jal, grp_load, grp_store};
    assign o_alu_op1_inv      = grp_branch & f3[0];
    assign o_alu_group_mux    = grp_mul;
    assign o_alu_div_mux      = grp_mul & f3[2];

    // without Zicsr only ecall/ebreak remain in the system class
    assign o_reg_write = full & !(grp_branch | grp_store) & !(grp_sys & !ext_zicsr);

    // an empty slot counts as supported
    assign o_supported = !i_valid | grp_load | grp_arr | grp_mul | auipc | grp_store |
                         grp_ari | lui | grp_branch | jalr | jal | i_sys_legal;

    assign o_inst_jal    = jal;
    assign o_inst_jalr   = jalr;
    assign o_inst_branch = grp_branch;
    assign o_inst_store  = grp_store;
    assign o_is_system   = grp_sys;

    assign o_sel_u = lui | auipc;
    assign o_sel_s = grp_store;
    assign o_sel_j = jal;

    always_comb
    begin
        assert final ($onehot0(o_alu_res))
        else $error("more than one alu result selected");
        assert final ($onehot(o_res_src))
        else $error("write-back source not one-hot");
    end

endmodule

`default_nettype wire

/* rv_imm_gen.sv */
`default_nettype none

module rv_imm_gen
(
    input  wire rv_isa_pkg::instr_t i_instr,
    input  wire                     i_sel_u,
    input  wire                     i_sel_s,
    input  wire                     i_sel_j,
    output rv_isa_pkg::imm_t        o_imm_i,
    output rv_isa_pkg::imm_t        o_imm_j
);

    rv_isa_pkg::imm_t imm_i;
    rv_isa_pkg::imm_t imm_s;
    rv_isa_pkg::imm_t imm_b;
    rv_isa_pkg::imm_t imm_u;
    rv_isa_pkg::imm_t imm_j;

    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign imm_u = {i_instr[31:12], 12'b0};

    // branch and jump offsets are halfword aligned
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb
    begin
        if (i_sel_u)
            o_imm_i = imm_u;
        else if (i_sel_s)
            o_imm_i = imm_s;
        else
            o_imm_i = imm_i;
    end

    assign o_imm_j = i_sel_j ? imm_j : imm_b;

endmodule

`default_nettype wire

/* rv_sys_decode.sv */
`default_nettype none

module rv_sys_decode
#(
    parameter bit ext_zicsr = 1'b1
)
(
    input  wire rv_isa_pkg::instr_t i_instr,
    input  wire                     i_is_system,
    input  wire                     i_stall,
    output rv_isa_pkg::csr_idx_t    o_csr_idx,
    output rv_isa_pkg::reg_idx_t    o_csr_imm,
    output logic                    o_csr_imm_sel,
    output logic                    o_csr_write,
    output logic                    o_csr_set,
    output logic                    o_csr_clear,
    output logic                    o_csr_read,
    output logic                    o_csr_req,
    output logic                    o_ebreak,
    output logic                    o_mret,
    output logic                    o_sys_legal
);

    rv_isa_pkg::funct3_t f3;
    logic [11:0] f12;
    logic priv;
    logic ecall;
    logic ebreak;
    logic mret;

    assign f3  = i_instr[14:12];
    assign f12 = i_instr[31:20];

    // funct3 zero selects the privileged group
    assign priv   = i_is_system & (f3 == rv_isa_pkg::f3_zero);
    assign ecall  = priv & (f12 == rv_isa_pkg::f12_ecall);
    assign ebreak = priv & (f12 == rv_isa_pkg::f12_ebreak);
    assign mret   = priv & (f12 == rv_isa_pkg::f12_mret) & ext_zicsr;

    assign o_csr_req = i_is_system & (f3 != rv_isa_pkg::f3_zero) & ext_zicsr;

    assign o_csr_idx     = f12;
    assign o_csr_imm     = i_instr[19:15];
    assign o_csr_imm_sel = f3[2];
    assign o_csr_read    = o_csr_req;

    // side effects must not fire twice while the stage is held
    assign o_csr_write = o_csr_req & (f3[1:0] == 2'b01) & !i_stall;
    assign o_csr_set   = o_csr_req & (f3[1:0] == 2'b10) & !i_stall;
    assign o_csr_clear = o_csr_req & (f3[1:0] == 2'b11) & !i_stall;

    assign o_ebreak    = ebreak;
    assign o_mret      = mret;
    assign o_sys_legal = ecall | ebreak | mret | o_csr_req;

    // is_system comes from the class decoder
    always_comb
    begin
        assert final ($onehot0({o_csr_write, o_csr_set, o_csr_clear}) &&
                      (!o_csr_req ||
                       i_instr[6:0] == {rv_isa_pkg::opc_system, rv_isa_pkg::opc_full}))
        else $error("csr pulses overlap or come from a non-system word");
    end

endmodule

`default_nettype wire

/* rv_decode.sv */
`default_nettype none

module rv_decode
#(
    parameter int iaddr_bits = 32,
    parameter bit ext_m      = 1'b1,
    parameter bit ext_zicsr  = 1'b1
)
(
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  wire                     i_stall,
    input  wire                     i_flush,
    input  wire                     i_ready,
    input  wire rv_isa_pkg::instr_t i_instruction,
    input  wire [iaddr_bits-1:1]    i_pc,
    output logic [iaddr_bits-1:1]   o_pc,
    output logic [iaddr_bits-1:1]   o_pc_next,
    output rv_isa_pkg::reg_idx_t    o_rd,
    output rv_isa_pkg::reg_idx_t    o_rs1,
    output rv_isa_pkg::reg_idx_t    o_rs2,
    output rv_isa_pkg::funct3_t     o_funct3,
    output rv_isa_pkg::imm_t        o_imm_i,
    output rv_isa_pkg::imm_t        o_imm_j,
    output rv_ctrl_pkg::alu_res_t   o_alu_res,
    output rv_ctrl_pkg::op2_src_t   o_op2_src,
    output rv_ctrl_pkg::res_src_t   o_res_src,
    output logic                    o_op1_src,
    output logic                    o_alu_add_override,
    output logic                    o_alu_op1_inv,
    output logic                    o_alu_op2_inv,
    output logic                    o_alu_group_mux,
    output logic                    o_alu_div_mux,
    output logic                    o_reg_write,
    output logic                    o_supported,
    output logic                    o_inst_jal,
    output logic                    o_inst_jalr,
    output logic                    o_inst_branch,
    output logic                    o_inst_store,
    output rv_isa_pkg::csr_idx_t    o_csr_idx,
    output rv_isa_pkg::reg_idx_t    o_csr_imm,
    output logic                    o_csr_imm_sel,
    output logic                    o_csr_write,
    output logic                    o_csr_set,
    output logic                    o_csr_clear,
    output logic                    o_csr_read,
    output logic                    o_csr_req,
    output logic                    o_ebreak,
    output logic                    o_mret
);

    rv_isa_pkg::instr_t instr;
    logic valid;
    logic is_system;
    logic sys_legal;
    logic sel_u;
    logic sel_s;
    logic sel_j;

    rv_decode_reg
    #(
        .iaddr_bits         (iaddr_bits)
    )
    u_reg
    (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .i_stall            (i_stall),
        .i_flush            (i_flush),
        .i_ready            (i_ready),
        .i_instruction      (i_instruction),
        .i_pc               (i_pc),
        .o_instr            (instr),
        .o_valid            (valid),
        .o_pc               (o_pc),
        .o_pc_next          (o_pc_next)
    );

    rv_class_decode
    #(
        .ext_m              (ext_m),
        .ext_zicsr          (ext_zicsr)
    )
    u_class
    (
        .i_instr            (instr),
        .i_valid            (valid),
        .i_sys_legal        (sys_legal),
        .o_rd               (o_rd),
        .o_rs1              (o_rs1),
        .o_rs2              (o_rs2),
        .o_funct3           (o_funct3),
        .o_alu_res          (o_alu_res),
        .o_op2_src          (o_op2_src),
        .o_res_src          (o_res_src),
        .o_op1_src          (o_op1_src),
        .o_alu_add_override (o_alu_add_override),
        .o_alu_op1_inv      (o_alu_op1_inv),
        .o_alu_op2_inv      (o_alu_op2_inv),
        .o_alu_group_mux    (o_alu_group_mux),
        .o_alu_div_mux      (o_alu_div_mux),
        .o_reg_write        (o_reg_write),
        .o_supported        (o_supported),
        .o_inst_jal         (o_inst_jal),
        .o_inst_jalr        (o_inst_jalr),
        .o_inst_branch      (o_inst_branch),
        .o_inst_store       (o_inst_store),
        .o_is_system        (is_system),
        .o_sel_u            (sel_u),
        .o_sel_s            (sel_s),
        .o_sel_j            (sel_j)
    );

    rv_imm_gen
    u_imm
    (
        .i_instr            (instr),
        .i_sel_u            (sel_u),
        .i_sel_s            (sel_s),
        .i_sel_j            (sel_j),
        .o_imm_i            (o_imm_i),
        .o_imm_j            (o_imm_j)
    );

    rv_sys_decode
    #(
        .ext_zicsr          (ext_zicsr)
    )
    u_sys
    (
        .i_instr            (instr),
        .i_is_system        (is_system),
        .i_stall            (i_stall),
        .o_csr_idx          (o_csr_idx),
        .o_csr_imm          (o_csr_imm),
        .o_csr_imm_sel      (o_csr_imm_sel),
        .o_csr_write        (o_csr_write),
        .o_csr_set          (o_csr_set),
        .o_csr_clear        (o_csr_clear),
        .o_csr_read         (o_csr_read),
        .o_csr_req          (o_csr_req),
        .o_ebreak           (o_ebreak),
        .o_mret             (o_mret),
        .o_sys_legal        (sys_legal)
    );

endmodule

`default_nettype wire

/* tb_rv_decode.sv */
`default_nettype none

module tb_rv_decode;

    localparam int max_lines  = 200;
    localparam int max_cycles = 1000;
    localparam int n_cols     = 21;

    logic                    i_clk;
    logic                    i_arst_n;
    logic                    i_stall;
    logic                    i_flush;
    logic                    i_ready;
    rv_isa_pkg::instr_t      i_instruction;
    logic [31:1]             i_pc;
    logic [31:1]             o_pc;
    logic [31:1]             o_pc_next;
    rv_isa_pkg::reg_idx_t    o_rd;
    rv_isa_pkg::reg_idx_t    o_rs1;
    rv_isa_pkg::reg_idx_t    o_rs2;
    rv_isa_pkg::funct3_t     o_funct3;
    rv_isa_pkg::imm_t        o_imm_i;
    rv_isa_pkg::imm_t        o_imm_j;
    rv_ctrl_pkg::alu_res_t   o_alu_res;
    rv_ctrl_pkg::op2_src_t   o_op2_src;
    rv_ctrl_pkg::res_src_t   o_res_src;
    logic                    o_op1_src;
    logic                    o_alu_add_override;
    logic                    o_alu_op1_inv;
    logic                    o_alu_op2_inv;
    logic                    o_alu_group_mux;
    logic                    o_alu_div_mux;
    logic                    o_reg_write;
    logic                    o_supported;
    logic                    o_inst_jal;
    logic                    o_inst_jalr;
    logic                    o_inst_branch;
    logic                    o_inst_store;
    rv_isa_pkg::csr_idx_t    o_csr_idx;
    rv_isa_pkg::reg_idx_t    o_csr_imm;
    logic                    o_csr_imm_sel;
    logic                    o_csr_write;
    logic                    o_csr_set;
    logic                    o_csr_clear;
    logic                    o_csr_read;
    logic                    o_csr_req;
    logic                    o_ebreak;
    logic                    o_mret;

    logic [31:0] col [0:n_cols-1];
    logic [5:0]  ctl;
    logic [3:0]  cls;
    logic [6:0]  csr;
    rv_isa_pkg::instr_t held_word;
    int          fd;
    int          n_lines;
    int          n_read;
    int          code;
    bit          done;
    string       line;

    rv_decode dut_i
    (
        .i_clk              (i_clk),
        .i_arst_n           (i_arst_n),
        .i_stall            (i_stall),
        .i_flush            (i_flush),
        .i_ready            (i_ready),
        .i_instruction      (i_instruction),
        .i_pc               (i_pc),
        .o_pc               (o_pc),
        .o_pc_next          (o_pc_next),
        .o_rd               (o_rd),
        .o_rs1              (o_rs1),
        .o_rs2              (o_rs2),
        .o_funct3           (o_funct3),
        .o_imm_i            (o_imm_i),
        .o_imm_j            (o_imm_j),
        .o_alu_res          (o_alu_res),
        .o_op2_src          (o_op2_src),
        .o_res_src          (o_res_src),
        .o_op1_src          (o_op1_src),
        .o_alu_add_override (o_alu_add_override),
        .o_alu_op1_inv      (o_alu_op1_inv),
        .o_alu_op2_inv      (o_alu_op2_inv),
        .o_alu_group_mux    (o_alu_group_mux),
        .o_alu_div_mux      (o_alu_div_mux),
        .o_reg_write        (o_reg_write),
        .o_supported        (o_supported),
        .o_inst_jal         (o_inst_jal),
        .o_inst_jalr        (o_inst_jalr),
        .o_inst_branch      (o_inst_branch),
        .o_inst_store       (o_inst_store),
        .o_csr_idx          (o_csr_idx),
        .o_csr_imm          (o_csr_imm),
        .o_csr_imm_sel      (o_csr_imm_sel),
        .o_csr_write        (o_csr_write),
        .o_csr_set          (o_csr_set),
        .o_csr_clear        (o_csr_clear),
        .o_csr_read         (o_csr_read),
        .o_csr_req          (o_csr_req),
        .o_ebreak           (o_ebreak),
        .o_mret             (o_mret)
    );

    assign ctl = {o_op1_src, o_alu_add_override, o_alu_op1_inv, o_alu_op2_inv,
                  o_alu_group_mux, o_alu_div_mux};
    assign cls = {o_inst_jal, o_inst_jalr, o_inst_branch, o_inst_store};
    assign csr = {o_csr_write, o_csr_set, o_csr_clear, o_csr_read, o_csr_imm_sel,
                  o_ebreak, o_mret};

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // watchdog against a stuck run
    initial
    begin
        for (int i = 0; i < max_cycles; i++)
            @(posedge i_clk);
        stop_on_error("simulation did not finish within the cycle limit");
    end

    initial
    begin
        i_arst_n      = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_ready       = 1'b0;
        i_instruction = '0;
        i_pc          = '0;
        held_word     = '0;
        n_lines       = 0;
        done          = 1'b0;

        fd = $fopen("rv_decode_stim.txt", "r");
        if (fd == 0)
            stop_on_error("could not open the stimulus file rv_decode_stim.txt");

        repeat (3) @(posedge i_clk);
        #2;
        i_arst_n = 1'b1;

        while (!done)
        begin
            code = $fgets(line, fd);
            if (code == 0)
                done = 1'b1;
            else if (line.len() > 1 && line[0] != "#")
            begin
                n_read = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                    col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                    col[14], col[15], col[16], col[17], col[18], col[19], col[20]);
                if (n_read != n_cols)
                    stop_on_error("malformed line in the stimulus file");
                n_lines++;
                if (n_lines > max_lines)
                    stop_on_error("stimulus file has more lines than allowed");

                i_stall       = col[0][0];
                i_flush       = col[1][0];
                i_ready       = col[2][0];
                i_instruction = col[3];
                i_pc          = col[4][30:0];

                // word the stage should hold after this edge
                if (col[1][0])
                    held_word = '0;
                else if (!col[0][0] && col[2][0])
                    held_word = col[3];
                else if (!col[0][0])
                    held_word = '0;

                // outputs settle one edge after capture
                @(posedge i_clk);
                #1;
                check("o_rd", 32'(o_rd), col[5]);
                check("o_rs1", 32'(o_rs1), col[6]);
                check("o_rs2", 32'(o_rs2), col[7]);
                check("o_funct3", 32'(o_funct3), 32'(held_word[14:12]));
                check("o_imm_i", o_imm_i, col[8]);
                check("o_imm_j", o_imm_j, col[9]);
                check("o_alu_res", 32'(o_alu_res), col[10]);
                check("o_op2_src", 32'(o_op2_src), col[11]);
                check("o_res_src", 32'(o_res_src), col[12]);
                check("alu control", 32'(ctl), col[13]);
                check("class flags", 32'(cls), col[14]);
                check("o_reg_write", 32'(o_reg_write), col[15]);
                check("o_supported", 32'(o_supported), col[16]);
                check("csr and system", 32'(csr), col[17]);
                check("o_csr_req", 32'(o_csr_req), 32'(col[17][3]));
                check("o_csr_idx", 32'(o_csr_idx), col[18]);
                check("o_csr_imm", 32'(o_csr_imm), col[19]);
                check("o_pc", 32'(o_pc), col[20]);
                check("o_pc_next", 32'(o_pc_next), 32'(col[20][30:0] + 31'd2));
                #1;
            end
        end
        $fclose(fd);

        if (n_lines == 0)
        begin
            $display("stimulus file holds no test lines");
            $display("*** FAILED ***");
            $fatal(1);
        end
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rv_decode_stim.txt */
# stall flush ready instr pc | rd rs1 rs2 imm_i imm_j alu op2 res ctl cls rw sup csr cidx cimm pc
# ctl={op1_src,add_ovr,op1_inv,op2_inv,grp,div} cls={jal,jalr,br,st} csr={w,s,c,rd,isel,ebrk,mret}
0 0 1 002081b3 40 03 01 02 00000002 00000802 8 1 1 00 0 1 1 00 002 01 40
0 0 1 407302b3 42 05 06 07 00000407 00000c04 8 1 1 04 0 1 1 00 407 06 42
0 0 1 40a4d433 44 08 09 0a 0000040a 00000408 4 1 1 04 0 1 1 04 40a 09 44
0 0 1 ffb62593 46 0b 0c 1b fffffffb ffffffea 1 2 1 04 0 1 1 00 ffb 0c 46
0 0 1 0f077693 48 0d 0e 10 000000f0 000008ec 2 2 1 00 0 1 1 04 0f0 0e 48
0 0 1 00812783 4a 0f 02 08 00000008 0000080e 8 2 4 10 0 1 1 00 008 02 4a
0 0 1 00532623 4c 0c 06 05 0000000c 0000000c 8 2 1 10 1 0 1 00 005 06 4c
0 0 1 00208863 4e 10 01 02 00000002 00000010 1 1 1 04 2 0 1 00 002 01 4e
0 0 1 100000ef 50 01 00 00 00000100 00000100 0 4 2 30 8 1 1 00 100 00 50
0 0 1 00008067 52 00 01 00 00000000 00000000 0 2 2 00 4 1 1 00 000 01 52
0 0 1 123453b7 54 07 00 03 12345000 00000926 0 2 1 10 0 1 1 04 123 08 54
0 0 1 80000497 56 09 00 00 80000000 fffff808 0 2 1 30 0 1 1 00 800 00 56
0 0 1 340110f3 58 01 02 00 00000340 00000b40 0 1 1 00 0 1 1 48 340 02 58
1 0 1 00108093 60 01 02 00 00000340 00000b40 0 1 1 00 0 1 1 08 340 02 58
0 0 1 3052e1f3 5c 03 05 05 00000305 00000b02 0 1 1 00 0 1 1 2c 305 05 5c
0 0 1 30023073 5e 00 04 00 00000300 00000300 0 1 1 00 0 1 1 18 300 04 5e
0 1 1 002081b3 70 00 00 00 00000000 00000000 0 1 1 00 0 0 1 00 000 00 5e
0 0 0 002081b3 80 00 00 00 00000000 00000000 0 1 1 00 0 0 1 00 000 00 80
0 0 1 00012087 90 01 02 00 00000000 00000800 0 1 1 00 0 1 0 00 000 02 90
0 0 1 ffffffff 92 1f 1f 1f ffffffff fffffffe 0 1 1 04 0 1 0 04 fff 1f 92
0 0 1 022081b3 94 03 01 02 00000022 00000822 0 1 1 02 0 1 1 00 022 01 94
0 0 1 0220c1b3 96 03 01 02 00000022 00000822 0 1 1 03 0 1 1 04 022 01 96
0 0 1 00000073 98 00 00 00 00000000 00000000 0 1 1 00 0 1 1 00 000 00 98
0 0 1 00100073 9a 00 00 01 00000001 00000000 0 1 1 00 0 1 1 02 001 00 9a
0 0 1 30200073 9c 00 00 02 00000302 00000300 0 1 1 00 0 1 1 01 302 00 9c

/* flist.f */
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_decode_reg.sv
rv_class_decode.sv
rv_imm_gen.sv
rv_sys_decode.sv
rv_decode.sv
tb_rv_decode.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_rv_decode -o sim_rv_decode

./obj_dir/sim_rv_decode > sim.log 2>&1 || true
cat sim.log

grep -qF "*** PASSED ***" sim.log
